/* compile.f */
cache_pkg.sv
mem_bus_pkg.sv
cache_store_if.sv
cache_ram.sv
cache_lookup.sv
cache_miss_fsm.sv
dcache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - cache_pkg.sv
  - mem_bus_pkg.sv
  - cache_store_if.sv
  - cache_ram.sv
  - cache_lookup.sv
  - cache_miss_fsm.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mem_model.sv
      - tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps
/*
 * data cache testbench
 * drives CPU loads and stores, keeps a flat reference memory and
 * compares every completed read against it
 */
module tb_dcache;

	localparam int NUM_WAYS     = 2;
	localparam int INDEX_WIDTH  = 2;
	localparam int OFFSET_WIDTH = 2;
	localparam int WORD_BITS    = 8;
	localparam int TIMEOUT      = 2000;
	localparam int RANDOM_OPS   = 300;

	logic clk;
	logic rst;
	logic [31:0] cpu_addr;
	cache_pkg::byte_en_t cpu_byte_en;
	logic cpu_read;
	logic cpu_write;
	cache_pkg::word_t cpu_wr_data;
	cache_pkg::word_t cpu_rd_data;
	logic cpu_stall;
	logic [31:0] mem_addr;
	logic mem_addr_valid, mem_we, mem_wr_valid, mem_wr_last;
	cache_pkg::word_t mem_wr_data;
	logic mem_addr_ready, mem_rd_valid, mem_wr_ready, mem_wr_done;
	cache_pkg::word_t mem_rd_data;
	int burst_errors;
	int wb_count;

	int errors;
	int timeouts;
	int seed;
	cache_pkg::word_t ref_mem [2 ** WORD_BITS];

	tb_clock_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(10)) u_clock_gen (.clk, .rst);

	dcache_top #(
		.NUM_WAYS     (NUM_WAYS),
		.INDEX_WIDTH  (INDEX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_dcache_top (.*);

	tb_mem_model #(.OFFSET_WIDTH(OFFSET_WIDTH), .WORD_BITS(WORD_BITS)) u_mem_model (.*);

	function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_word,
		input cache_pkg::word_t new_word, input cache_pkg::byte_en_t be);
		cache_pkg::word_t result;
		result = old_word;
		for (int b = 0; b < 4; b++)
			if (be[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		return result;
	endfunction

	function automatic cache_pkg::word_t expected_word(input logic [31:0] addr);
		return ref_mem[addr[WORD_BITS+1:2]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
		end
	endtask

	// completed accesses: reads compared, writes folded into the reference
	always @(posedge clk) begin
		if (rst && !cpu_stall) begin
			if (cpu_read)
				check_value("cpu_rd_data", cpu_rd_data, expected_word(cpu_addr));
			else if (cpu_write)
				ref_mem[cpu_addr[WORD_BITS+1:2]] = merge_bytes(expected_word(cpu_addr),
					cpu_wr_data, cpu_byte_en);
		end
	end

	task automatic wait_done(output int stall_cycles);
		stall_cycles = 0;
		@(posedge clk);
		while (cpu_stall && stall_cycles < TIMEOUT) begin
			stall_cycles++;
			@(posedge clk);
		end
		if (cpu_stall) begin
			timeouts++;
			$display("timeout: cache still stalled after %0d cycles, address 0x%08h",
				TIMEOUT, cpu_addr);
		end
	endtask

	task automatic cpu_access(input logic write, input logic [31:0] addr,
		input cache_pkg::word_t data, input cache_pkg::byte_en_t be, output int stall_cycles);
		@(negedge clk);
		cpu_addr = addr;
		cpu_read = !write;
		cpu_write = write;
		cpu_wr_data = data;
		cpu_byte_en = be;
		wait_done(stall_cycles);
	endtask

	initial begin
		int n;
		int cycles;
		logic [31:0] r;
		logic [31:0] addr;
		cpu_addr = '0;
		cpu_byte_en = '0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_wr_data = '0;
		errors = 0;
		timeouts = 0;
		seed = 32'h045a_c21c;
		for (int i = 0; i < 2 ** WORD_BITS; i++)
			ref_mem[i] = i ^ 32'h5a5a_0000;

		cycles = 0;
		while (rst !== 1'b1 && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== 1'b1) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		@(negedge clk);
		check_value("cpu_stall", cpu_stall, 0);
		check_value("mem_addr_valid", mem_addr_valid, 0);
		check_value("mem_wr_valid", mem_wr_valid, 0);
		check_value("mem_we", mem_we, 0);

		// cold line, then the rest of it from the cache
		cpu_access(1'b0, 32'h000, '0, '0, n);
		check_value("cpu_stall on cold read", n != 0, 1);
		for (int w = 1; w < 4; w++) begin
			cpu_access(1'b0, 32'(w * 4), '0, '0, n);
			check_value("stall cycles on read hit", n, 0);
		end

		cpu_access(1'b1, 32'h008, 32'hdead_beef, 4'b0101, n);
		check_value("stall cycles on write hit", n, 0);
		cpu_access(1'b0, 32'h008, '0, '0, n);

		// set 0 now holds a dirty line, two more dirty lines push both out
		cpu_access(1'b1, 32'h100, 32'h1111_aaaa, 4'b1111, n);
		cpu_access(1'b1, 32'h144, 32'h2222_bbbb, 4'b0011, n);
		cpu_access(1'b1, 32'h188, 32'h3333_cccc, 4'b1100, n);
		check_value("write bursts", wb_count, 2);
		cpu_access(1'b0, 32'h100, '0, '0, n);
		cpu_access(1'b0, 32'h144, '0, '0, n);
		cpu_access(1'b0, 32'h188, '0, '0, n);
		cpu_access(1'b0, 32'h008, '0, '0, n);

		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = $random(seed);
			addr = 32'(r[5:0]) << 2;   // 64-word window
			cpu_access(r[8], addr, $random(seed), r[12:9], n);
		end

		@(negedge clk);
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		repeat (2) @(posedge clk);
		$display("run complete: %0d errors, %0d timeouts", errors + burst_errors, timeouts);
		if (errors + burst_errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps
/*
 * burst memory slave for the cache testbench
 * backing word memory with a fixed fill, random stalls on every
 * handshake, and checks on each write burst it captures
 */
module tb_mem_model #(
	parameter int OFFSET_WIDTH = 2,
	parameter int WORD_BITS    = 8    // 256 words, 1 KiB
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] mem_addr,
	input  logic        mem_addr_valid,
	input  logic        mem_we,
	input  logic [31:0] mem_wr_data,
	input  logic        mem_wr_valid,
	input  logic        mem_wr_last,
	output logic        mem_addr_ready,
	output logic        mem_rd_valid,
	output logic [31:0] mem_rd_data,
	output logic        mem_wr_ready,
	output logic        mem_wr_done,
	output int          burst_errors,
	output int          wb_count
);
	localparam int BURST_LEN = 2 ** OFFSET_WIDTH;

	typedef enum logic [1:0] {M_IDLE, M_READ, M_WRITE} model_state_t;

	model_state_t mstate;
	logic [31:0] mem [2 ** WORD_BITS];
	logic [WORD_BITS-1:0] base;   // first word of the burst
	int count;
	int seed;
	logic go_addr;
	logic go_data;

	initial begin
		seed = 32'h045a_c21c;
		for (int i = 0; i < 2 ** WORD_BITS; i++)
			mem[i] = i ^ 32'h5a5a_0000;
	end

	assign mem_addr_ready = (mstate == M_IDLE) && go_addr;
	assign mem_wr_ready   = (mstate == M_WRITE) && go_data;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			mstate <= M_IDLE;
			base <= '0;
			count <= 0;
			go_addr <= 1'b0;
			go_data <= 1'b0;
			mem_rd_valid <= 1'b0;
			mem_rd_data <= '0;
			mem_wr_done <= 1'b0;
			burst_errors <= 0;
			wb_count <= 0;
		end else begin
			go_addr <= ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
			go_data <= ($random(seed) & 3) != 0;
			mem_rd_valid <= 1'b0;
			mem_wr_done <= 1'b0;
			case (mstate)
				M_IDLE: begin
					if (mem_addr_valid && mem_addr_ready) begin
						base <= mem_addr[WORD_BITS+1:2];
						count <= 0;
						mstate <= mem_we ? M_WRITE : M_READ;
						if (mem_addr[OFFSET_WIDTH+1:0] != '0) begin
							burst_errors <= burst_errors + 1;
							$display("memory model: burst address 0x%08h is not line aligned",
								mem_addr);
						end
					end else if (mem_wr_valid && !mem_addr_valid) begin
						burst_errors <= burst_errors + 1;
						$display("memory model: write word sent outside a burst at %0t", $time);
					end
				end
				M_READ: begin
					if (($random(seed) & 3) != 0) begin
						mem_rd_valid <= 1'b1;
						mem_rd_data <= mem[base + WORD_BITS'(count)];
						count <= count + 1;
						if (count == BURST_LEN - 1)
							mstate <= M_IDLE;
					end
				end
				M_WRITE: begin
					if (mem_wr_valid && mem_wr_ready) begin
						mem[base + WORD_BITS'(count)] <= mem_wr_data;
						count <= count + 1;
						if (mem_wr_last !== (count == BURST_LEN - 1)) begin
							burst_errors <= burst_errors + 1;
							$display("** Error at %0t: mem_wr_last = %0b, expected %0b",
								$time, mem_wr_last, count == BURST_LEN - 1);
						end
						if (count == BURST_LEN - 1) begin   // whole line written
							mem_wr_done <= 1'b1;
							wb_count <= wb_count + 1;
							mstate <= M_IDLE;
						end
					end
				end
				default: mstate <= M_IDLE;
			endcase
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps
/*
 * testbench clock and reset
 * free-running clock, active-low reset released on a falling edge
 */
module tb_clock_gen #(
	parameter real PERIOD_NS    = 10.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;   // away from the active edge
	end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps
/*
 * set-associative write-back data cache
 * CPU load/store port in front of a burst memory bus; ties the lookup,
 * the miss controller and the per-way tag and data arrays together
 */
module dcache_top #(
	parameter int NUM_WAYS     = 2,
	parameter int INDEX_WIDTH  = 2,
	parameter int OFFSET_WIDTH = 2
) (
	input  logic                             clk,
	input  logic                             rst,
	// CPU side
	input  logic [cache_pkg::ADDR_WIDTH-1:0] cpu_addr,
	input  cache_pkg::byte_en_t              cpu_byte_en,
	input  logic                             cpu_read,
	input  logic                             cpu_write,
	input  cache_pkg::word_t                 cpu_wr_data,
	output cache_pkg::word_t                 cpu_rd_data,
	output logic                             cpu_stall,
	// memory side
	output logic [cache_pkg::ADDR_WIDTH-1:0] mem_addr,
	output logic                             mem_addr_valid,
	output logic                             mem_we,
	output cache_pkg::word_t                 mem_wr_data,
	output logic                             mem_wr_valid,
	output logic                             mem_wr_last,
	input  logic                             mem_addr_ready,
	input  logic                             mem_rd_valid,
	input  cache_pkg::word_t                 mem_rd_data,
	input  logic                             mem_wr_ready,
	input  logic                             mem_wr_done
);
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	cache_store_if #(
		.NUM_WAYS     (NUM_WAYS),
		.INDEX_WIDTH  (INDEX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) store_bus ();

	cache_lookup #(
		.NUM_WAYS     (NUM_WAYS),
		.INDEX_WIDTH  (INDEX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_lookup (
		.cpu_addr (cpu_addr),
		.store    (store_bus.lookup)
	);

	cache_miss_fsm #(
		.NUM_WAYS     (NUM_WAYS),
		.INDEX_WIDTH  (INDEX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_miss_fsm (
		.clk, .rst,
		.cpu_addr, .cpu_byte_en, .cpu_read, .cpu_write, .cpu_wr_data,
		.cpu_rd_data, .cpu_stall,
		.mem_addr, .mem_addr_valid, .mem_we, .mem_wr_data, .mem_wr_valid, .mem_wr_last,
		.mem_addr_ready, .mem_rd_valid, .mem_rd_data, .mem_wr_ready, .mem_wr_done,
		.store (store_bus.ctrl)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_ram #(
			.DEPTH_WIDTH (INDEX_WIDTH),
			.payload_t   (cache_pkg::line_meta_t)
		) u_meta_ram (
			.clk, .rst,
			.rd_addr (store_bus.index),
			.rd_data (store_bus.rd_meta[w]),
			.we      (store_bus.meta_we && (store_bus.meta_way == WAY_W'(w))),
			.wr_addr (store_bus.index),
			.wr_data (store_bus.meta_wdata)
		);

		// one word per entry, addressed by set and word offset
		cache_ram #(
			.DEPTH_WIDTH (INDEX_WIDTH + OFFSET_WIDTH),
			.payload_t   (cache_pkg::word_t)
		) u_data_ram (
			.clk, .rst,
			.rd_addr ({store_bus.index, store_bus.rd_off}),
			.rd_data (store_bus.rd_data[w]),
			.we      (store_bus.data_we && (store_bus.data_way == WAY_W'(w))),
			.wr_addr ({store_bus.index, store_bus.data_off}),
			.wr_data (store_bus.data_wdata)
		);
	end

endmodule

/* cache_miss_fsm.sv */
`timescale 1ns/1ps
/*
 * cache miss controller
 * serves hits, merges write-hit bytes, runs the writeback and refill
 * bursts on the memory bus and stalls the CPU until the line is in
 */
module cache_miss_fsm #(
	parameter int NUM_WAYS     = 2,
	parameter int INDEX_WIDTH  = 2,
	parameter int OFFSET_WIDTH = 2
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [cache_pkg::ADDR_WIDTH-1:0] cpu_addr,
	input  cache_pkg::byte_en_t              cpu_byte_en,
	input  logic                             cpu_read,
	input  logic                             cpu_write,
	input  cache_pkg::word_t                 cpu_wr_data,
	output cache_pkg::word_t                 cpu_rd_data,
	output logic                             cpu_stall,
	output logic [cache_pkg::ADDR_WIDTH-1:0] mem_addr,
	output logic                             mem_addr_valid,
	output logic                             mem_we,
	output cache_pkg::word_t                 mem_wr_data,
	output logic                             mem_wr_valid,
	output logic                             mem_wr_last,
	input  logic                             mem_addr_ready,
	input  logic                             mem_rd_valid,
	input  cache_pkg::word_t                 mem_rd_data,
	input  logic                             mem_wr_ready,
	input  logic                             mem_wr_done,
	cache_store_if.ctrl                      store
);
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
	localparam int LINE_LSB = OFFSET_WIDTH + cache_pkg::BYTE_SEL_WIDTH;
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - LINE_LSB;
	localparam logic [OFFSET_WIDTH-1:0] LAST_BEAT = '1;

	mem_bus_pkg::miss_state_t state;
	logic [OFFSET_WIDTH-1:0] beat;        // word position inside the burst
	logic [WAY_W-1:0] vway;
	logic [WAY_W-1:0] rr_ptr;
	logic [OFFSET_WIDTH-1:0] cpu_off;
	logic cpu_req;
	logic miss;
	logic wb_needed;
	logic [cache_pkg::ADDR_WIDTH-1:0] victim_addr;
	logic [cache_pkg::ADDR_WIDTH-1:0] refill_addr;
	cache_pkg::word_t merged;

	assign cpu_off   = cpu_addr[cache_pkg::BYTE_SEL_WIDTH +: OFFSET_WIDTH];
	assign cpu_req   = cpu_read || cpu_write;
	assign miss      = cpu_req && !store.hit;
	assign wb_needed = store.victim_meta.valid && store.victim_meta.dirty;

	assign victim_addr = {store.victim_meta.tag[TAG_WIDTH-1:0], store.index,
		{LINE_LSB{1'b0}}};
	assign refill_addr = {cpu_addr[cache_pkg::ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};

	// hits go through with no wait state
	assign cpu_stall   = cpu_req && (state != mem_bus_pkg::IDLE || !store.hit);
	assign cpu_rd_data = store.rd_data[store.hit_way];

	// writeback words come straight from the victim's data array
	assign store.rd_off = (state == mem_bus_pkg::IDLE) ? cpu_off : beat;
	assign mem_wr_data  = store.rd_data[vway];
	assign mem_wr_last  = mem_wr_valid && (beat == LAST_BEAT);
	assign store.rr_ptr = rr_ptr;

	always_comb begin
		merged = store.rd_data[store.hit_way];
		for (int b = 0; b < cache_pkg::DATA_WIDTH / 8; b++) begin
			if (cpu_byte_en[b])
				merged[8*b +: 8] = cpu_wr_data[8*b +: 8];
		end
	end

	// array write port steering
	always_comb begin
		store.data_we    = 1'b0;
		store.data_way   = store.hit_way;
		store.data_off   = cpu_off;
		store.data_wdata = merged;
		store.meta_we    = 1'b0;
		store.meta_way   = store.hit_way;
		store.meta_wdata = '{valid: 1'b1, dirty: 1'b1, tag: store.tag};
		case (state)
			mem_bus_pkg::IDLE: begin
				store.data_we = cpu_write && store.hit;   // write hit
				store.meta_we = cpu_write && store.hit;
			end
			mem_bus_pkg::WB_DONE: begin
				store.meta_we    = mem_wr_done;   // line leaves the cache
				store.meta_way   = vway;
				store.meta_wdata = '0;
			end
			mem_bus_pkg::RF_BURST: begin
				store.data_we    = mem_rd_valid;
				store.data_way   = vway;
				store.data_off   = beat;
				store.data_wdata = mem_rd_data;
			end
			mem_bus_pkg::RF_FINISH: begin
				store.meta_we    = 1'b1;
				store.meta_way   = vway;
				store.meta_wdata = '{valid: 1'b1, dirty: 1'b0, tag: store.tag};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state          <= mem_bus_pkg::IDLE;
			beat           <= '0;
			rr_ptr         <= '0;
			mem_addr_valid <= 1'b0;
			mem_we         <= mem_bus_pkg::BUS_READ;
			mem_wr_valid   <= 1'b0;
		end else begin
			if (mem_addr_valid && mem_addr_ready)
				mem_addr_valid <= 1'b0;   // address taken
			case (state)
				mem_bus_pkg::IDLE: begin
					if (miss) begin
						beat           <= '0;
						mem_addr_valid <= 1'b1;
						if (wb_needed) begin
							state        <= mem_bus_pkg::WB_BURST;
							mem_we       <= mem_bus_pkg::BUS_WRITE;
							mem_wr_valid <= 1'b1;
						end else begin
							state  <= mem_bus_pkg::RF_BURST;
							mem_we <= mem_bus_pkg::BUS_READ;
						end
					end
				end
				mem_bus_pkg::WB_BURST: begin
					if (mem_wr_valid && mem_wr_ready) begin
						if (beat == LAST_BEAT) begin
							mem_wr_valid <= 1'b0;
							state        <= mem_bus_pkg::WB_DONE;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				mem_bus_pkg::WB_DONE: begin
					if (mem_wr_done) begin   // now fetch the requested line
						beat           <= '0;
						mem_addr_valid <= 1'b1;
						mem_we         <= mem_bus_pkg::BUS_READ;
						state          <= mem_bus_pkg::RF_BURST;
					end
				end
				mem_bus_pkg::RF_BURST: begin
					if (mem_rd_valid) begin
						beat <= beat + 1'b1;
						if (beat == LAST_BEAT)
							state <= mem_bus_pkg::RF_FINISH;
					end
				end
				mem_bus_pkg::RF_FINISH: begin
					rr_ptr <= (rr_ptr == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_ptr + 1'b1;
					state  <= mem_bus_pkg::IDLE;
				end
				default: state <= mem_bus_pkg::IDLE;
			endcase
		end
	end

	// burst address and victim way, loaded when a burst starts
	always_ff @(posedge clk) begin
		if (state == mem_bus_pkg::IDLE && miss) begin
			vway     <= store.victim_way;
			mem_addr <= wb_needed ? victim_addr : refill_addr;
		end else if (state == mem_bus_pkg::WB_DONE && mem_wr_done) begin
			mem_addr <= refill_addr;
		end
	end

	a_addr_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_addr_valid && !mem_addr_ready |=> mem_addr_valid && $stable(mem_addr))
		else $error("burst address withdrawn or changed before mem_addr_ready");

	// victim line must not change under a stalled writeback word
	a_wr_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_wr_valid && !mem_wr_ready |=> mem_wr_valid && $stable(mem_wr_data))
		else $error("write word not held while mem_wr_ready low");

endmodule

/* cache_lookup.sv */
`timescale 1ns/1ps
/*
 * tag lookup
 * splits the CPU address, compares the tag against every way of the
 * selected set and picks the hit way and the replacement victim
 */
module cache_lookup #(
	parameter int NUM_WAYS     = 2,
	parameter int INDEX_WIDTH  = 2,
	parameter int OFFSET_WIDTH = 2
) (
	input  logic [cache_pkg::ADDR_WIDTH-1:0] cpu_addr,
	cache_store_if.lookup                    store
);
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
	localparam int LINE_LSB = OFFSET_WIDTH + cache_pkg::BYTE_SEL_WIDTH;
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - LINE_LSB;

	logic [NUM_WAYS-1:0] way_hit;
	logic [NUM_WAYS-1:0] way_free;

	assign store.index = cpu_addr[LINE_LSB +: INDEX_WIDTH];

	// tag zero-extended to the metadata field
	always_comb begin
		store.tag = '0;
		store.tag[TAG_WIDTH-1:0] = cpu_addr[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
	end

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w]  = store.rd_meta[w].valid && (store.rd_meta[w].tag == store.tag);
			way_free[w] = !store.rd_meta[w].valid;
		end
	end

	// scan downward so the lowest matching way wins
	always_comb begin
		store.hit        = |way_hit;
		store.hit_way    = '0;
		store.victim_way = store.rr_ptr;   // set full, take round-robin way
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w])
				store.hit_way = WAY_W'(w);
			if (way_free[w])
				store.victim_way = WAY_W'(w);
		end
		store.victim_meta = store.rd_meta[store.victim_way];
	end

	// a refill only ever loads a tag that missed in the set
	always_comb begin
		a_one_hit: assert final ($onehot0(way_hit))
			else $error("tag present in more than one way of set %0d", store.index);
	end

endmodule

/* cache_ram.sv */
`timescale 1ns/1ps
/*
 * register array storage
 * asynchronous read, one synchronous write port; the entry type is
 * a parameter so the same array holds tags or data words
 */
module cache_ram #(
	parameter int  DEPTH_WIDTH = 2,
	parameter type payload_t   = logic [31:0]
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [DEPTH_WIDTH-1:0] rd_addr,
	output payload_t               rd_data,
	input  logic                   we,
	input  logic [DEPTH_WIDTH-1:0] wr_addr,
	input  payload_t               wr_data
);
	localparam int DEPTH = 2 ** DEPTH_WIDTH;

	payload_t mem [DEPTH];

	// cleared entries read back as invalid metadata
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign rd_data = mem[rd_addr];   // same-cycle read

endmodule

/* cache_store_if.sv */
`timescale 1ns/1ps
/*
 * cache storage interface
 * joins the miss controller, the tag lookup and the per-way arrays
 */
interface cache_store_if #(
	parameter int NUM_WAYS     = 2,
	parameter int INDEX_WIDTH  = 2,
	parameter int OFFSET_WIDTH = 2
);
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	// from the miss controller
	logic [OFFSET_WIDTH-1:0]          rd_off;
	logic                             meta_we;
	logic [WAY_W-1:0]                 meta_way;
	cache_pkg::line_meta_t            meta_wdata;
	logic                             data_we;
	logic [WAY_W-1:0]                 data_way;
	logic [OFFSET_WIDTH-1:0]          data_off;
	cache_pkg::word_t                 data_wdata;
	logic [WAY_W-1:0]                 rr_ptr;

	// from the lookup
	logic [INDEX_WIDTH-1:0]           index;
	logic [cache_pkg::TAG_MAX-1:0]    tag;
	logic                             hit;
	logic [WAY_W-1:0]                 hit_way;
	logic [WAY_W-1:0]                 victim_way;
	cache_pkg::line_meta_t            victim_meta;

	// from the arrays, one entry per way
	cache_pkg::line_meta_t            rd_meta [NUM_WAYS];
	cache_pkg::word_t                 rd_data [NUM_WAYS];

	modport ctrl (
		output rd_off, meta_we, meta_way, meta_wdata,
		output data_we, data_way, data_off, data_wdata, rr_ptr,
		input  index, tag, hit, hit_way, victim_way, victim_meta, rd_data
	);

	modport lookup (
		input  rd_meta, rr_ptr,
		output index, tag, hit, hit_way, victim_way, victim_meta
	);

	modport store (
		input  index, rd_off, meta_we, meta_way, meta_wdata,
		input  data_we, data_way, data_off, data_wdata,
		output rd_meta, rd_data
	);

endinterface

/* mem_bus_pkg.sv */
/*
 * memory bus side definitions
 * transfer direction codes and the states of the miss controller
 */
package mem_bus_pkg;

	localparam logic BUS_READ  = 1'b0;   // refill burst
	localparam logic BUS_WRITE = 1'b1;   // writeback burst

	// miss controller
	typedef enum logic [2:0] {
		IDLE      = 3'd0,   // serving hits
		WB_BURST  = 3'd1,   // victim line going out
		WB_DONE   = 3'd2,   // waiting for write completion
		RF_BURST  = 3'd3,   // line coming in
		RF_FINISH = 3'd4    // metadata update
	} miss_state_t;

endpackage

/* cache_pkg.sv */
/*
 * data cache common definitions
 * word and byte-enable types, address widths and the per-line
 * metadata record kept in the tag arrays
 */
package cache_pkg;

	localparam int ADDR_WIDTH = 32;                 // byte address
	localparam int DATA_WIDTH = 32;
	localparam int BYTE_SEL_WIDTH = $clog2(DATA_WIDTH / 8);

	// widest tag the metadata can hold, upper bits unused for wider lines
	localparam int TAG_MAX = 28;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [DATA_WIDTH/8-1:0] byte_en_t;

	// one line of a way, all zero means invalid
	typedef struct packed {
		logic               valid;
		logic               dirty;
		logic [TAG_MAX-1:0] tag;
	} line_meta_t;

endpackage
